//--- verilog/ide_defs.svh
////////////////////
// ide port shared sizes
// fifo depth, dma word count width
// and sequencer stage count
////////////////////

`ifndef IDE_DEFS_SVH
`define IDE_DEFS_SVH

// log2 of write fifo depth
// 16 words covers a few cycles of host slack
`define IDE_FIFO_AW 4

// dma word count width
// 256 words is one 512-byte sector
`define IDE_LEN_W 9

// one-hot sequencer length
// stage 0 strobe low, stage 2 strobe high
// stage 3 cs release, stage 4 done
`define IDE_ST_N 5

`endif

//--- verilog/ide_pkg.sv
////////////////////
// ide port types
// cycle source and dma state enums
////////////////////

`default_nettype none

package ide_pkg;

	// who owns the running bus cycle
	// travels with read data as rd_src
	typedef enum logic [1:0]
	{
		SRC_NONE = 2'd0,
		SRC_Z80  = 2'd1,
		SRC_DMA  = 2'd2
	} src_e;

	// dma word loop
	// idle, word requested, word in flight
	typedef enum logic [1:0]
	{
		DMA_IDLE = 2'd0,
		DMA_REQ  = 2'd1,
		DMA_WAIT = 2'd2
	} dma_state_e;

endpackage

`default_nettype wire

//--- verilog/ide_wr_fifo.sv
////////////////////
// write data fifo
// host pushes words, dma engine pops
// head word visible without latency
////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "ide_defs.svh"

module ide_wr_fifo
(
	input  wire        clk,
	input  wire        reset,

	// host side
	input  wire        push,
	input  wire [15:0] push_data,
	output wire        full,

	// dma side
	input  wire        pop,
	output wire [15:0] pop_data,
	output wire        empty
);

	localparam int DEPTH = 1 << `IDE_FIFO_AW;

	logic [15:0]            mem [0:DEPTH-1];
	logic [`IDE_FIFO_AW-1:0] wr_ptr;
	logic [`IDE_FIFO_AW-1:0] rd_ptr;
	// one extra bit to tell full from empty
	logic [`IDE_FIFO_AW:0]   count;

	logic do_push;
	logic do_pop;

	assign full  = (count == DEPTH[`IDE_FIFO_AW:0]);
	assign empty = (count == '0);

	// push on full is dropped, pop on empty ignored
	assign do_push = push && !full;
	assign do_pop  = pop && !empty;

	// head word straight from storage
	assign pop_data = mem[rd_ptr];

	// storage array
	always_ff @(posedge clk)
		if (do_push)
			mem[wr_ptr] <= push_data;

	// pointers wrap naturally at depth
	always_ff @(posedge clk)
		if (reset)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end
		else
		begin
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;

			// simultaneous push and pop keeps the count
			if (do_push && !do_pop)
				count <= count + 1'b1;
			else if (do_pop && !do_push)
				count <= count - 1'b1;
		end

	// host must honour fill_full
	a_no_push_full: assert property (@(posedge clk) disable iff (reset)
		push |-> !full);

	// dma engine pops only after seeing data
	a_no_pop_empty: assert property (@(posedge clk) disable iff (reset)
		pop |-> !empty);

endmodule

`default_nettype wire

//--- verilog/ide_dma_ctrl.sv
////////////////////
// dma word counter
// turns a sector length into word requests
// for the pio sequencer
////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "ide_defs.svh"

module ide_dma_ctrl
(
	input  wire                  clk,
	input  wire                  reset,

	// control
	input  wire                  start,
	input  wire                  rnw,
	input  wire [`IDE_LEN_W-1:0] len,
	output wire                  busy,

	// write fifo
	input  wire                  fifo_empty,
	output wire                  fifo_pop,
	input  wire [15:0]           fifo_data,

	// to sequencer
	output wire                  dma_req,
	output wire                  dma_rnw,
	output wire [15:0]           dma_out,
	input  wire                  rdy,
	input  wire                  rdy_stb
);

	ide_pkg::dma_state_e state;

	logic                  rnw_q;
	// words still to complete
	logic [`IDE_LEN_W-1:0] left;
	// word popped for the running write
	logic [15:0]           out_q;

	logic accept;

	// reads go at once, writes need a word in the fifo
	assign dma_req = (state == ide_pkg::DMA_REQ) && (rnw_q || !fifo_empty);

	// dma wins arbitration, so req with rdy is our go
	assign accept = dma_req && rdy;

	// pop together with acceptance of a write
	assign fifo_pop = accept && !rnw_q;

	assign dma_rnw = rnw_q;
	assign busy    = (state != ide_pkg::DMA_IDLE);

	// head word until accepted, then the popped copy
	assign dma_out = (state == ide_pkg::DMA_WAIT) ? out_q : fifo_data;

	always_ff @(posedge clk)
		if (fifo_pop)
			out_q <= fifo_data;

	always_ff @(posedge clk)
		if (reset)
		begin
			state <= ide_pkg::DMA_IDLE;
			rnw_q <= 1'b1;
			left  <= '0;
		end
		else
			case (state)
				ide_pkg::DMA_IDLE:
					// zero length means nothing to move
					if (start && (len != '0))
					begin
						rnw_q <= rnw;
						left  <= len;
						state <= ide_pkg::DMA_REQ;
					end

				ide_pkg::DMA_REQ:
					if (accept)
						state <= ide_pkg::DMA_WAIT;

				ide_pkg::DMA_WAIT:
					// only our cycle can end while waiting
					if (rdy_stb)
					begin
						left  <= left - 1'b1;
						state <= (left == 1) ? ide_pkg::DMA_IDLE : ide_pkg::DMA_REQ;
					end

				default:
					state <= ide_pkg::DMA_IDLE;
			endcase

	// no request outside a transfer
	a_idle_no_req: assert property (@(posedge clk) disable iff (reset)
		(state == ide_pkg::DMA_IDLE) |-> !dma_req);

	// sequencer must really start our cycle, rdy low next
	a_accept_taken: assert property (@(posedge clk) disable iff (reset)
		accept |=> !rdy);

endmodule

`default_nettype wire

//--- verilog/ide_pio.sv
////////////////////
// pio-4 cycle sequencer
// dma/z80 source select, one-hot stages,
// read data capture and return
////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "ide_defs.svh"

module ide_pio
(
	input  wire               clk,
	input  wire               reset,

	// dma requester
	input  wire               dma_req,
	input  wire               dma_rnw,
	input  wire [15:0]        dma_out,

	// z80 requester
	input  wire               z80_req,
	input  wire               z80_rnw,
	input  wire [15:0]        z80_out,
	input  wire [ 2:0]        z80_a,
	input  wire               z80_cs0_n,
	input  wire               z80_cs1_n,

	// drive data in
	input  wire [15:0]        ide_in,

	// status and read return
	output wire               rdy,
	output logic              rdy_stb,
	output logic [15:0]       rd_data,
	output logic              rd_stb,
	output ide_pkg::src_e     rd_src,

	// drive bus
	output wire  [15:0]       ide_out,
	output wire  [ 2:0]       ide_a,
	output logic              ide_dir,
	output logic              ide_cs0_n,
	output logic              ide_cs1_n,
	output logic              ide_rd_n,
	output logic              ide_wr_n
);

	// one-hot stage shift
	// go enters at bit 0
	logic [`IDE_ST_N-1:0] st;

	// owner and direction of the running cycle
	ide_pkg::src_e cur_src;
	logic          cur_rnw;

	logic go;
	logic running;
	logic sel_dma;

	assign running = |st;

	// idle also through the rdy_stb cycle
	// 6 clocks per access
	assign rdy = !running && !rdy_stb;

	// dma has priority
	assign go = (dma_req || z80_req) && rdy;

	// before go the requester picks the source
	// during a cycle the latched owner does
	assign sel_dma = running ? (cur_src == ide_pkg::SRC_DMA) : dma_req;

	assign ide_out = sel_dma ? dma_out : z80_out;
	// dma always hits data register 0 on cs0
	assign ide_a   = sel_dma ? 3'd0 : z80_a;

	// stage clocking
	always_ff @(posedge clk)
		if (reset)
			st <= '0;
		else
			st <= {st[`IDE_ST_N-2:0], go};

	// bus control per stage
	always_ff @(posedge clk)
		if (reset)
		begin
			ide_dir   <= 1'b1;
			ide_cs0_n <= 1'b1;
			ide_cs1_n <= 1'b1;
			ide_rd_n  <= 1'b1;
			ide_wr_n  <= 1'b1;
			cur_src   <= ide_pkg::SRC_NONE;
			cur_rnw   <= 1'b1;
		end
		else if (go)
		begin
			// address setup with cs and dir first
			cur_src   <= dma_req ? ide_pkg::SRC_DMA : ide_pkg::SRC_Z80;
			cur_rnw   <= dma_req ? dma_rnw : z80_rnw;
			ide_dir   <= dma_req ? dma_rnw : z80_rnw;
			ide_cs0_n <= dma_req ? 1'b0 : z80_cs0_n;
			ide_cs1_n <= dma_req ? 1'b1 : z80_cs1_n;
		end
		else if (st[0])
		begin
			// t2 starts with one strobe low
			ide_rd_n <= !cur_rnw;
			ide_wr_n <= cur_rnw;
		end
		else if (st[2])
		begin
			ide_rd_n <= 1'b1;
			ide_wr_n <= 1'b1;
		end
		else if (st[3])
		begin
			// back to bus idle
			ide_dir   <= 1'b1;
			ide_cs0_n <= 1'b1;
			ide_cs1_n <= 1'b1;
		end

	// completion strobes one clock after the last stage
	always_ff @(posedge clk)
		if (reset)
		begin
			rdy_stb <= 1'b0;
			rd_stb  <= 1'b0;
			rd_src  <= ide_pkg::SRC_NONE;
		end
		else
		begin
			rdy_stb <= st[4];
			rd_stb  <= st[4] && cur_rnw;
			if (st[4])
				rd_src <= cur_src;
		end

	// sample drive data as rd_n rises
	always_ff @(posedge clk)
		if (st[2] && cur_rnw)
			rd_data <= ide_in;

	// never read and write together
	a_one_strobe: assert property (@(posedge clk) disable iff (reset)
		!(!ide_rd_n && !ide_wr_n));

	// idle sequencer leaves both strobes released
	a_idle_strobes: assert property (@(posedge clk) disable iff (reset)
		rdy |-> (ide_rd_n && ide_wr_n));

endmodule

`default_nettype wire

//--- verilog/ide_top.sv
////////////////////
// ide port top
// write fifo, dma counter, pio sequencer
////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "ide_defs.svh"

module ide_top
(
	input  wire                  clk,
	input  wire                  reset,

	// host fill
	input  wire [15:0]           fill_data,
	input  wire                  fill_stb,
	output wire                  fill_full,

	// dma control
	input  wire                  dma_start,
	input  wire                  dma_rnw,
	input  wire [`IDE_LEN_W-1:0] dma_len,
	output wire                  dma_busy,

	// z80 access
	input  wire [15:0]           z80_out,
	input  wire [ 2:0]           z80_a,
	input  wire                  z80_cs0_n,
	input  wire                  z80_cs1_n,
	input  wire                  z80_req,
	input  wire                  z80_rnw,

	// read return and status
	output wire [15:0]           rd_data,
	output wire                  rd_stb,
	output ide_pkg::src_e        rd_src,
	output wire                  rdy,
	output wire                  rdy_stb,

	// drive bus
	output wire [15:0]           ide_out,
	input  wire [15:0]           ide_in,
	output wire [ 2:0]           ide_a,
	output wire                  ide_dir,
	output wire                  ide_cs0_n,
	output wire                  ide_cs1_n,
	output wire                  ide_rd_n,
	output wire                  ide_wr_n
);

	// fifo to dma
	wire [15:0] pop_data;
	wire        empty;
	wire        pop;

	// dma to sequencer
	wire        dma_req;
	wire        dma_cyc_rnw;
	wire [15:0] dma_out;

	ide_wr_fifo u_fifo
	(
		.clk       (clk),
		.reset     (reset),
		.push      (fill_stb),
		.push_data (fill_data),
		.full      (fill_full),
		.pop       (pop),
		.pop_data  (pop_data),
		.empty     (empty)
	);

	ide_dma_ctrl u_dma
	(
		.clk        (clk),
		.reset      (reset),
		.start      (dma_start),
		.rnw        (dma_rnw),
		.len        (dma_len),
		.busy       (dma_busy),
		.fifo_empty (empty),
		.fifo_pop   (pop),
		.fifo_data  (pop_data),
		.dma_req    (dma_req),
		.dma_rnw    (dma_cyc_rnw),
		.dma_out    (dma_out),
		.rdy        (rdy),
		.rdy_stb    (rdy_stb)
	);

	ide_pio u_pio
	(
		.clk       (clk),
		.reset     (reset),
		.dma_req   (dma_req),
		.dma_rnw   (dma_cyc_rnw),
		.dma_out   (dma_out),
		.z80_req   (z80_req),
		.z80_rnw   (z80_rnw),
		.z80_out   (z80_out),
		.z80_a     (z80_a),
		.z80_cs0_n (z80_cs0_n),
		.z80_cs1_n (z80_cs1_n),
		.ide_in    (ide_in),
		.rdy       (rdy),
		.rdy_stb   (rdy_stb),
		.rd_data   (rd_data),
		.rd_stb    (rd_stb),
		.rd_src    (rd_src),
		.ide_out   (ide_out),
		.ide_a     (ide_a),
		.ide_dir   (ide_dir),
		.ide_cs0_n (ide_cs0_n),
		.ide_cs1_n (ide_cs1_n),
		.ide_rd_n  (ide_rd_n),
		.ide_wr_n  (ide_wr_n)
	);

endmodule

`default_nettype wire

//--- tb/tb_clkgen.sv
////////////////////
// testbench clock and reset
// 20 ns clock, reset held 4 cycles
////////////////////

`timescale 1ns/1ps
`default_nettype none

module tb_clkgen
(
	output logic clk,
	output logic reset
);

	initial
		clk = 1'b0;

	// 50 MHz
	always
		#10 clk = ~clk;

	// synchronous release after 4 rising edges
	initial
	begin
		reset = 1'b1;
		repeat (4) @(posedge clk);
		reset <= 1'b0;
	end

endmodule

`default_nettype wire

//--- tb/tb_ide.sv
////////////////////
// ide port testbench
// drive model with task file and sector buffer
// stimulus table, bus log and checks
////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "ide_defs.svh"

module tb_ide;

	localparam int          TIMEOUT = 2000;
	localparam logic [31:0] SEED    = 32'h2d69d34c;

	// table operations
	localparam logic [2:0] OP_ZWR  = 3'd0;
	localparam logic [2:0] OP_ZRD  = 3'd1;
	localparam logic [2:0] OP_FILL = 3'd2;
	localparam logic [2:0] OP_DWR  = 3'd3;
	localparam logic [2:0] OP_DRD  = 3'd4;
	localparam logic [2:0] OP_PRIO = 3'd5;

	// cs 1 selects cs1
	// x is expected value or dma length
	typedef struct packed
	{
		logic [2:0]  op;
		logic        cs;
		logic [2:0]  a;
		logic [15:0] d;
		logic [15:0] x;
	} entry_t;

	wire                  clk;
	wire                  reset;
	logic [15:0]          fill_data;
	logic                 fill_stb;
	wire                  fill_full;
	logic                 dma_start;
	logic                 dma_rnw;
	logic [`IDE_LEN_W-1:0] dma_len;
	wire                  dma_busy;
	logic [15:0]          z80_out;
	logic [ 2:0]          z80_a;
	logic                 z80_cs0_n;
	logic                 z80_cs1_n;
	logic                 z80_req;
	logic                 z80_rnw;
	wire  [15:0]          rd_data;
	wire                  rd_stb;
	ide_pkg::src_e        rd_src;
	wire                  rdy;
	wire                  rdy_stb;
	wire  [15:0]          ide_out;
	wire  [15:0]          ide_in;
	wire  [ 2:0]          ide_a;
	wire                  ide_dir;
	wire                  ide_cs0_n;
	wire                  ide_cs1_n;
	wire                  ide_rd_n;
	wire                  ide_wr_n;

	// drive model state
	logic [15:0] regs [0:15];
	logic [15:0] data_buf [0:255];
	logic [7:0]  buf_ptr;
	integer      seed;
	logic [21:0] log_q [$];
	logic [17:0] rd_q [$];
	int          rdy_cnt;
	int          rd_cnt;
	int          fall_cyc;
	int          rise_cyc;
	int          cyc;
	logic        str_prev;
	logic        str_now;
	logic [15:0] held;
	wire  [15:0] rd_word;

	// test state
	entry_t      tbl [$];
	logic [15:0] fill_q [$];
	logic [7:0]  exp_ptr;

	tb_clkgen u_clk
	(
		.clk   (clk),
		.reset (reset)
	);

	ide_top dut
	(
		.clk       (clk),
		.reset     (reset),
		.fill_data (fill_data),
		.fill_stb  (fill_stb),
		.fill_full (fill_full),
		.dma_start (dma_start),
		.dma_rnw   (dma_rnw),
		.dma_len   (dma_len),
		.dma_busy  (dma_busy),
		.z80_out   (z80_out),
		.z80_a     (z80_a),
		.z80_cs0_n (z80_cs0_n),
		.z80_cs1_n (z80_cs1_n),
		.z80_req   (z80_req),
		.z80_rnw   (z80_rnw),
		.rd_data   (rd_data),
		.rd_stb    (rd_stb),
		.rd_src    (rd_src),
		.rdy       (rdy),
		.rdy_stb   (rdy_stb),
		.ide_out   (ide_out),
		.ide_in    (ide_in),
		.ide_a     (ide_a),
		.ide_dir   (ide_dir),
		.ide_cs0_n (ide_cs0_n),
		.ide_cs1_n (ide_cs1_n),
		.ide_rd_n  (ide_rd_n),
		.ide_wr_n  (ide_wr_n)
	);

	// cs0 address 0 is the data port
	// everything else hits the task file
	assign rd_word = (!ide_cs0_n && ide_a == 3'd0) ? data_buf[buf_ptr] : regs[{ide_cs0_n, ide_a}];
	assign ide_in  = ide_rd_n ? 16'h0000 : rd_word;

	always @(posedge clk)
		cyc <= cyc + 1;

	// expected log word with exactly one chip select low
	function automatic logic [21:0] bus_entry(input logic cs, input logic [2:0] a,
		input logic [15:0] d, input logic dir);
		return {dir, ~cs, cs, a, d};
	endfunction

	// drive model sampled mid-cycle
	initial
	begin
		int k;
		seed = SEED;
		for (k = 0; k < 256; k++)
			data_buf[k[7:0]] = 16'($random(seed));
		// task file pattern from cs and address
		for (k = 0; k < 16; k++)
			regs[k[3:0]] = 16'hc300 | 16'(k);
		buf_ptr  = 8'd0;
		str_prev = 1'b1;
		held     = 16'h0000;
		forever
		begin
			@(negedge clk);
			if (!reset)
			begin
				if (rdy_stb)
					rdy_cnt++;
				if (rd_stb)
				begin
					rd_cnt++;
					rd_q.push_back({rd_src, rd_data});
				end
				str_now = ide_rd_n && ide_wr_n;
				if (!str_now)
					held = ide_rd_n ? ide_out : ide_in;
				if (str_prev && !str_now)
					fall_cyc = cyc;
				// strobe released so the cycle is complete
				if (!str_prev && str_now)
				begin
					rise_cyc = cyc;
					log_q.push_back({ide_dir, ide_cs1_n, ide_cs0_n, ide_a, held});
					if (!ide_dir && !(!ide_cs0_n && ide_a == 3'd0))
						regs[{ide_cs0_n, ide_a}] = held;
					else if (ide_dir && !ide_cs0_n && ide_a == 3'd0)
						buf_ptr = buf_ptr + 8'd1;
				end
				str_prev = str_now;
			end
		end
	end

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("FAIL: see errors above");
		$fatal(1);
	endtask

	task automatic check(input logic [31:0] got, input logic [31:0] exp, input string msg);
		if (got !== exp)
			fail_run($sformatf("mismatch at %0d ns: %s, got %0h, expected %0h",
				$time, msg, got, exp));
	endtask

	task automatic reset_done;
		int t;
		t = 0;
		@(negedge clk);
		while (reset)
		begin
			if (t >= TIMEOUT)
				fail_run("timeout waiting for reset to end");
			t++;
			@(negedge clk);
		end
	endtask

	task automatic wait_rdy_stb(output int at_cyc);
		int t;
		t = 0;
		@(negedge clk);
		while (!rdy_stb)
		begin
			if (t >= TIMEOUT)
				fail_run("timeout waiting for rdy_stb");
			t++;
			@(negedge clk);
		end
		at_cyc = cyc;
	endtask

	task automatic wait_rdy_high;
		int t;
		t = 0;
		@(negedge clk);
		while (!rdy)
		begin
			if (t >= TIMEOUT)
				fail_run("timeout waiting for rdy to return");
			t++;
			@(negedge clk);
		end
	endtask

	task automatic wait_busy_low;
		int t;
		t = 0;
		@(negedge clk);
		while (dma_busy)
		begin
			if (t >= TIMEOUT)
				fail_run("timeout waiting for dma_busy to fall");
			t++;
			@(negedge clk);
		end
	endtask

	// one register access
	// returns go and rdy_stb cycles
	task automatic z80_access(input logic rnw, input logic cs, input logic [2:0] a,
		input logic [15:0] d, output int go_cyc, output int stb_cyc);
		int t;
		t = 0;
		@(posedge clk);
		z80_rnw   <= rnw;
		z80_a     <= a;
		z80_cs0_n <= cs;
		z80_cs1_n <= !cs;
		z80_out   <= d;
		z80_req   <= 1'b1;
		// our go is rdy low once dma has let go
		@(negedge clk);
		while (rdy || dma_busy)
		begin
			if (t >= TIMEOUT)
				fail_run("timeout waiting for z80 access to start");
			t++;
			@(negedge clk);
		end
		go_cyc = cyc;
		@(posedge clk);
		z80_req <= 1'b0;
		wait_rdy_stb(stb_cyc);
		wait_rdy_high;
	endtask

	task automatic fill_word(input logic [15:0] d, input logic exp_full);
		@(negedge clk);
		check(32'(fill_full), 32'd0, "fill_full before push");
		@(posedge clk);
		fill_data <= d;
		fill_stb  <= 1'b1;
		@(posedge clk);
		fill_stb  <= 1'b0;
		@(negedge clk);
		check(32'(fill_full), 32'(exp_full), "fill_full after push");
		fill_q.push_back(d);
	endtask

	task automatic start_dma(input logic rnw, input logic [`IDE_LEN_W-1:0] len);
		@(posedge clk);
		dma_rnw   <= rnw;
		dma_len   <= len;
		dma_start <= 1'b1;
		@(posedge clk);
		dma_start <= 1'b0;
		// busy one edge after start
		@(negedge clk);
		check(32'(dma_busy), 32'd1, "dma_busy after start");
	endtask

	task automatic put(input logic [2:0] op, input logic cs, input logic [2:0] a,
		input logic [15:0] d, input logic [15:0] x);
		entry_t e;
		e.op = op;
		e.cs = cs;
		e.a  = a;
		e.d  = d;
		e.x  = x;
		tbl.push_back(e);
	endtask

	task automatic build_table;
		int i;
		put(OP_ZWR, 1'b1, 3'd6, 16'h00a5, 16'h0000);
		put(OP_ZWR, 1'b0, 3'd2, 16'h1234, 16'h0000);
		put(OP_ZRD, 1'b1, 3'd6, 16'h0000, 16'h00a5);
		put(OP_ZRD, 1'b0, 3'd2, 16'h0000, 16'h1234);
		// untouched register keeps its preload
		put(OP_ZRD, 1'b1, 3'd7, 16'h0000, 16'hc30f);
		// fill to full
		// the last push raises fill_full
		for (i = 0; i < 16; i++)
			put(OP_FILL, 1'b0, 3'd0, 16'h5a00 + 16'(i * 273), (i == 15) ? 16'd1 : 16'd0);
		put(OP_DWR, 1'b0, 3'd0, 16'h0000, 16'd16);
		put(OP_FILL, 1'b0, 3'd0, 16'hbeef, 16'd0);
		put(OP_FILL, 1'b0, 3'd0, 16'h0f0f, 16'd0);
		put(OP_DWR, 1'b0, 3'd0, 16'h0000, 16'd2);
		put(OP_DRD, 1'b0, 3'd0, 16'h0000, 16'd8);
		// z80 write raised inside a 4 word read burst
		put(OP_PRIO, 1'b1, 3'd3, 16'h7e57, 16'd4);
		put(OP_ZRD, 1'b1, 3'd3, 16'h0000, 16'h7e57);
	endtask

	task automatic apply_entry(input entry_t e);
		int go_c;
		int stb_c;
		int base;
		int rbase;
		int rdy0;
		int rd0;
		int n;
		int i;
		logic [15:0] w;
		base  = log_q.size();
		rbase = rd_q.size();
		rdy0  = rdy_cnt;
		rd0   = rd_cnt;
		n     = 32'(e.x);
		case (e.op)
			OP_ZWR:
			begin
				z80_access(1'b0, e.cs, e.a, e.d, go_c, stb_c);
				check(log_q.size(), base + 1, "z80 write log length");
				check(32'(log_q[base]), 32'(bus_entry(e.cs, e.a, e.d, 1'b0)), "z80 write cycle");
				check(rdy_cnt, rdy0 + 1, "rdy_stb count after z80 write");
				check(rd_cnt, rd0, "rd_stb count after z80 write");
			end
			OP_ZRD:
			begin
				z80_access(1'b1, e.cs, e.a, e.d, go_c, stb_c);
				// strobe low at go+1 and high at go+3
				// rdy_stb at go+5
				check(fall_cyc, go_c + 1, "read strobe low offset");
				check(rise_cyc, go_c + 3, "read strobe high offset");
				check(stb_c, go_c + 5, "rdy_stb offset");
				check(rd_q.size(), rbase + 1, "rd_stb count after z80 read");
				check(32'(rd_q[rbase]), 32'({ide_pkg::SRC_Z80, e.x}), "z80 read return");
				check(32'(log_q[base]), 32'(bus_entry(e.cs, e.a, e.x, 1'b1)), "z80 read cycle");
			end
			OP_FILL:
				fill_word(e.d, e.x[0]);
			OP_DWR:
			begin
				start_dma(1'b0, e.x[`IDE_LEN_W-1:0]);
				wait_busy_low;
				check(log_q.size(), base + n, "dma write log length");
				// fifo order on cs0 address 0
				for (i = 0; i < n; i++)
				begin
					w = fill_q.pop_front();
					check(32'(log_q[base + i]), 32'(bus_entry(1'b0, 3'd0, w, 1'b0)),
						"dma write word");
				end
				check(rd_q.size(), rbase, "rd_stb during dma write");
			end
			OP_DRD, OP_PRIO:
			begin
				start_dma(1'b1, e.x[`IDE_LEN_W-1:0]);
				if (e.op == OP_PRIO)
				begin
					// waits out the whole burst
					z80_access(1'b0, e.cs, e.a, e.d, go_c, stb_c);
					check(rdy_cnt, rdy0 + n + 1, "rdy_stb count after priority burst");
					check(log_q.size(), base + n + 1, "log length after priority burst");
					check(32'(log_q[base + n]), 32'(bus_entry(e.cs, e.a, e.d, 1'b0)),
						"z80 write after burst");
				end
				else
				begin
					wait_busy_low;
					check(log_q.size(), base + n, "dma read log length");
				end
				check(rd_q.size(), rbase + n, "rd_stb count after dma read");
				// sector buffer in order
				for (i = 0; i < n; i++)
				begin
					w = data_buf[exp_ptr];
					check(32'(rd_q[rbase + i]), 32'({ide_pkg::SRC_DMA, w}), "dma read return");
					check(32'(log_q[base + i]), 32'(bus_entry(1'b0, 3'd0, w, 1'b1)),
						"dma read cycle");
					exp_ptr = exp_ptr + 8'd1;
				end
			end
			default:
				fail_run("unknown operation in stimulus table");
		endcase
	endtask

	initial
	begin
		fill_data = 16'h0000;
		fill_stb  = 1'b0;
		dma_start = 1'b0;
		dma_rnw   = 1'b1;
		dma_len   = '0;
		z80_out   = 16'h0000;
		z80_a     = 3'd0;
		z80_cs0_n = 1'b1;
		z80_cs1_n = 1'b1;
		z80_req   = 1'b0;
		z80_rnw   = 1'b1;
		exp_ptr   = 8'd0;
		build_table;
		reset_done;
		// bus idle after reset
		check(32'(ide_rd_n), 32'd1, "rd_n after reset");
		check(32'(ide_wr_n), 32'd1, "wr_n after reset");
		check(32'(ide_cs0_n), 32'd1, "cs0_n after reset");
		check(32'(ide_cs1_n), 32'd1, "cs1_n after reset");
		check(32'(ide_dir), 32'd1, "dir after reset");
		check(32'(rdy), 32'd1, "rdy after reset");
		check(32'(rdy_stb), 32'd0, "rdy_stb after reset");
		check(32'(rd_stb), 32'd0, "rd_stb after reset");
		check(32'(dma_busy), 32'd0, "dma_busy after reset");
		foreach (tbl[k])
			apply_entry(tbl[k]);
		$display("PASS: all tests");
		$finish;
	end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+verilog
verilog/ide_pkg.sv
verilog/ide_wr_fifo.sv
verilog/ide_dma_ctrl.sv
verilog/ide_pio.sv
verilog/ide_top.sv
tb/tb_clkgen.sv
tb/tb_ide.sv

//--- run.sh
#!/bin/sh
# build and run the ide port testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
	-f vlog.f \
	--top-module tb_ide \
	-o tb_ide

./obj_dir/tb_ide
